/* common/exu_pkg.sv */
package exu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN       = 64;
    localparam int ITER_COUNT = 64;   // Cycles per multiply or divide

    typedef logic [XLEN-1:0]               xlen_t;
    typedef logic [4:0]                    reg_addr_t;
    typedef logic [$clog2(ITER_COUNT)-1:0] iter_cnt_t;

    // --------------------
    // Operation encoding
    // --------------------
    typedef enum logic [4:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_SLL  = 5'd2,
        OP_SLT  = 5'd3,
        OP_SLTU = 5'd4,
        OP_XOR  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_OR   = 5'd8,
        OP_AND  = 5'd9,
        OP_MUL  = 5'd10,   // Low half of product only
        OP_DIV  = 5'd11,
        OP_DIVU = 5'd12,
        OP_REM  = 5'd13,
        OP_REMU = 5'd14
    } alu_op_t;

    // Control FSM
    typedef enum logic [1:0] {
        EXU_IDLE = 2'd0,
        EXU_RUN  = 2'd1,   // Long operation in flight
        EXU_HOLD = 2'd2    // Result waiting on the memory stage
    } exu_state_t;

endpackage

/* exu/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
    input  alu_op_t op,
    input  xlen_t   src1,
    input  xlen_t   src2,
    input  logic    word_op,
    input  xlen_t   mul_result,
    input  xlen_t   div_quotient,
    input  xlen_t   div_remainder,
    output xlen_t   result
);

    logic [5:0] shamt;
    xlen_t      raw;

    assign shamt = src2[5:0];   // RV64 shift amount

    // --------------------
    // Operation select
    // --------------------
    always_comb begin
        case (op)
            OP_ADD: begin
                raw = src1 + src2;
            end
            OP_SUB: begin
                raw = src1 - src2;
            end
            OP_SLL: begin
                raw = src1 << shamt;
            end
            OP_SLT: begin
                raw = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            OP_SLTU: begin
                raw = {{(XLEN-1){1'b0}}, src1 < src2};
            end
            OP_XOR: begin
                raw = src1 ^ src2;
            end
            OP_SRL: begin
                raw = src1 >> shamt;
            end
            OP_SRA: begin
                raw = $signed(src1) >>> shamt;   // Arithmetic, keeps sign
            end
            OP_OR: begin
                raw = src1 | src2;
            end
            OP_AND: begin
                raw = src1 & src2;
            end
            // Long operations read the unit result registers
            OP_MUL: begin
                raw = mul_result;
            end
            OP_DIV, OP_DIVU: begin
                raw = div_quotient;
            end
            OP_REM, OP_REMU: begin
                raw = div_remainder;
            end
            default: begin
                raw = '0;
            end
        endcase
    end

    // Word forms only sign-extend the low half
    assign result = word_op ? {{(XLEN/2){raw[XLEN/2-1]}}, raw[XLEN/2-1:0]} : raw;

endmodule

/* exu/exu_multiplier.sv */
`timescale 1ns/1ps

module exu_multiplier import exu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  start,
    input  xlen_t multiplicand,
    input  xlen_t multiplier,
    output xlen_t product,
    output logic  done
);

    logic      busy;
    iter_cnt_t count;
    xlen_t     mcand_q;
    xlen_t     mplier_q;
    xlen_t     acc_in;
    xlen_t     mcand_in;
    xlen_t     mplier_in;
    xlen_t     acc_next;

    // First partial product is taken in the start cycle itself
    assign acc_in    = start ? '0 : product;
    assign mcand_in  = start ? multiplicand : mcand_q;
    assign mplier_in = start ? multiplier : mplier_q;
    assign acc_next  = acc_in + (mplier_in[0] ? mcand_in : '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
            product <= '0;
        end else begin
            done <= 1'b0;   // Single-cycle pulse
            if (start) begin
                busy    <= 1'b1;
                count   <= iter_cnt_t'(1);
                product <= acc_next;
            end else if (busy) begin
                count   <= count + 1'b1;
                product <= acc_next;
                if (count == iter_cnt_t'(ITER_COUNT - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Operand shifters, low 64 bits only so sign does not matter
    always_ff @(posedge clock) begin
        if (start || busy) begin
            mcand_q  <= mcand_in << 1;
            mplier_q <= mplier_in >> 1;
        end
    end

endmodule

/* exu/exu_divider.sv */
`timescale 1ns/1ps

module exu_divider import exu_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  start,
    input  logic  is_signed,
    input  xlen_t dividend,
    input  xlen_t divisor,
    output xlen_t quotient,
    output xlen_t remainder,
    output logic  done
);

    logic          busy;
    iter_cnt_t     count;
    xlen_t         rem_q;
    xlen_t         quo_q;
    xlen_t         dvs_q;
    logic          neg_quo;
    logic          neg_rem;
    xlen_t         dividend_abs;
    xlen_t         divisor_abs;
    xlen_t         rem_in;
    xlen_t         quo_in;
    xlen_t         dvs_in;
    logic [XLEN:0] shifted;
    logic [XLEN:0] trial;
    xlen_t         rem_next;
    xlen_t         quo_next;

    assign dividend_abs = (is_signed && dividend[XLEN-1]) ? -dividend : dividend;
    assign divisor_abs  = (is_signed && divisor[XLEN-1]) ? -divisor : divisor;

    // Step inputs come straight from the ports in the start cycle
    assign rem_in = start ? '0 : rem_q;
    assign quo_in = start ? dividend_abs : quo_q;
    assign dvs_in = start ? divisor_abs : dvs_q;

    // --------------------
    // One restoring step
    // --------------------
    always_comb begin
        shifted = {rem_in, quo_in[XLEN-1]};
        trial   = shifted - {1'b0, dvs_in};
        if (trial[XLEN]) begin   // Borrow, keep shifted value
            rem_next = shifted[XLEN-1:0];
            quo_next = {quo_in[XLEN-2:0], 1'b0};
        end else begin
            rem_next = trial[XLEN-1:0];
            quo_next = {quo_in[XLEN-2:0], 1'b1};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            count     <= '0;
            done      <= 1'b0;
            quotient  <= '0;
            remainder <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= 1'b1;
                count <= iter_cnt_t'(1);
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == iter_cnt_t'(ITER_COUNT - 1)) begin
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    // Overflow case wraps to the dividend on its own
                    quotient  <= neg_quo ? -quo_next : quo_next;
                    remainder <= neg_rem ? -rem_next : rem_next;
                end
            end
        end
    end

    // Working registers and sign fix-up flags
    always_ff @(posedge clock) begin
        if (start || busy) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
        if (start) begin
            dvs_q   <= divisor_abs;
            neg_quo <= is_signed && (dividend[XLEN-1] ^ divisor[XLEN-1]) && (divisor != '0);
            neg_rem <= is_signed && dividend[XLEN-1];   // Remainder follows dividend
        end
    end

endmodule

/* exu/exu_control.sv */
`timescale 1ns/1ps

module exu_control import exu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  alu_op_t op,
    input  logic    out_ready,
    input  logic    mul_done,
    input  logic    div_done,
    output logic    mul_start,
    output logic    div_start,
    output logic    div_signed,
    output logic    in_ready,
    output logic    out_valid
);

    exu_state_t state;
    exu_state_t next_state;
    logic       is_mul;
    logic       is_div;
    logic       unit_done;

    // --------------------
    // Operation classes
    // --------------------
    assign is_mul     = (op == OP_MUL);
    assign is_div     = (op == OP_DIV) || (op == OP_DIVU) || (op == OP_REM) || (op == OP_REMU);
    assign div_signed = (op == OP_DIV) || (op == OP_REM);
    assign unit_done  = mul_done || div_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= EXU_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        mul_start  = 1'b0;
        div_start  = 1'b0;
        out_valid  = 1'b0;
        in_ready   = 1'b0;
        case (state)
            EXU_IDLE: begin
                if (is_mul || is_div) begin
                    mul_start = in_valid && is_mul;
                    div_start = in_valid && is_div;
                    if (in_valid) begin
                        next_state = EXU_RUN;
                    end
                end else begin
                    out_valid = in_valid;   // Short op, no added latency
                    in_ready  = out_ready;
                end
            end
            EXU_RUN: begin
                out_valid = unit_done;
                in_ready  = out_ready && unit_done;
                if (unit_done) begin
                    next_state = out_ready ? EXU_IDLE : EXU_HOLD;
                end
            end
            EXU_HOLD: begin
                out_valid = 1'b1;
                in_ready  = out_ready;
                if (out_ready) begin
                    next_state = EXU_IDLE;
                end
            end
            default: begin
                next_state = EXU_IDLE;
            end
        endcase
    end

endmodule

/* design/exu_top.sv */
`timescale 1ns/1ps

module exu_top import exu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  alu_op_t   op,
    input  xlen_t     src1,
    input  xlen_t     src2,
    input  logic      word_op,
    input  reg_addr_t rd_addr,
    input  logic      wen,
    output logic      out_valid,
    input  logic      out_ready,
    output xlen_t     result,
    output reg_addr_t out_rd_addr,
    output logic      out_wen
);

    logic  mul_start;
    logic  div_start;
    logic  div_signed;
    logic  mul_done;
    logic  div_done;
    xlen_t mul_result;
    xlen_t div_quotient;
    xlen_t div_remainder;

    // Destination fields ride along with the operands
    assign out_rd_addr = rd_addr;
    assign out_wen     = wen;

    exu_control u_control (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .op         (op),
        .out_ready  (out_ready),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .div_signed (div_signed),
        .in_ready   (in_ready),
        .out_valid  (out_valid)
    );

    exu_alu u_alu (
        .op            (op),
        .src1          (src1),
        .src2          (src2),
        .word_op       (word_op),
        .mul_result    (mul_result),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .result        (result)
    );

    exu_multiplier u_multiplier (
        .clock        (clock),
        .reset        (reset),
        .start        (mul_start),
        .multiplicand (src1),
        .multiplier   (src2),
        .product      (mul_result),
        .done         (mul_done)
    );

    exu_divider u_divider (
        .clock     (clock),
        .reset     (reset),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (src1),
        .divisor   (src2),
        .quotient  (div_quotient),
        .remainder (div_remainder),
        .done      (div_done)
    );

endmodule

/* verif/exu_checker.sv */
`timescale 1ns/1ps

module exu_checker import exu_pkg::*; (
    input logic      clock,
    input logic      reset,
    input logic      in_ready,
    input alu_op_t   op,
    input xlen_t     src1,
    input xlen_t     src2,
    input logic      word_op,
    input reg_addr_t rd_addr,
    input logic      wen,
    input logic      out_valid,
    input logic      out_ready,
    input xlen_t     result,
    input reg_addr_t out_rd_addr,
    input logic      out_wen
);

    localparam xlen_t MIN_VALUE = {1'b1, {(XLEN-1){1'b0}}};

    int    fail_count = 0;
    xlen_t expected;

    // --------------------
    // Reference model
    // --------------------
    function automatic xlen_t model(input alu_op_t o, input xlen_t a, input xlen_t b,
                                    input logic w);
        xlen_t              r;
        xlen_t              sq;
        xlen_t              sr;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic               ovf;
        sa  = a;
        sb  = b;
        ovf = (a == MIN_VALUE) && (b == '1);   // Signed overflow case
        sq  = '0;
        sr  = '0;
        if (b != '0 && !ovf) begin
            sq = sa / sb;   // Signed quotient and remainder
            sr = sa % sb;
        end
        case (o)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_SLL:  r = a << b[5:0];
            OP_SLT:  r = (sa < sb) ? 64'd1 : 64'd0;
            OP_SLTU: r = (a < b) ? 64'd1 : 64'd0;
            OP_XOR:  r = a ^ b;
            OP_SRL:  r = a >> b[5:0];
            OP_SRA:  r = sa >>> b[5:0];
            OP_OR:   r = a | b;
            OP_AND:  r = a & b;
            OP_MUL:  r = a * b;   // Low half only
            OP_DIV:  r = (b == '0) ? '1 : (ovf ? a : sq);
            OP_DIVU: r = (b == '0) ? '1 : a / b;
            OP_REM:  r = (b == '0) ? a : (ovf ? '0 : sr);
            OP_REMU: r = (b == '0) ? a : a % b;
            default: r = '0;
        endcase
        if (w) begin
            r = {{(XLEN/2){r[XLEN/2-1]}}, r[XLEN/2-1:0]};
        end
        return r;
    endfunction

    assign expected = model(op, src1, src2, word_op);

    // --------------------
    // Properties
    // --------------------
    assert property (@(posedge clock) disable iff (reset)
        (out_valid && out_ready) |-> (result == expected))
    else begin
        fail_count++;
        $error("mismatch at %0t: result got %h expected %h",
               $time, $sampled(result), $sampled(expected));
    end

    // Stalled output must not move
    assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(result)
            && $stable(out_rd_addr) && $stable(out_wen)))
    else begin
        fail_count++;
        $error("Output changed at %0t while the memory stage was stalling", $time);
    end

    assert property (@(posedge clock) disable iff (reset) in_ready |-> out_ready)
    else begin
        fail_count++;
        $error("in_ready was high at %0t while out_ready was low", $time);
    end

    assert property (@(posedge clock) $fell(reset) |-> !out_valid)
    else begin
        fail_count++;
        $error("out_valid was high in the first cycle after reset at %0t", $time);
    end

    assert property (@(posedge clock) disable iff (reset)
        out_valid |-> (out_rd_addr == rd_addr) && (out_wen == wen))
    else begin
        fail_count++;
        $error("mismatch at %0t: out_rd_addr got %h expected %h, out_wen got %b expected %b",
               $time, $sampled(out_rd_addr), $sampled(rd_addr),
               $sampled(out_wen), $sampled(wen));
    end

endmodule

bind exu_top exu_checker u_checker (.*);

/* verif/exu_tb.sv */
`timescale 1ns/1ps

module exu_tb import exu_pkg::*; ();

    localparam xlen_t MIN_VALUE = {1'b1, {(XLEN-1){1'b0}}};
    localparam int    TIMEOUT   = 200;   // Cycles per transfer

    logic        clock;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    alu_op_t     op;
    xlen_t       src1;
    xlen_t       src2;
    logic        word_op;
    reg_addr_t   rd_addr;
    logic        wen;
    logic        out_valid;
    logic        out_ready;
    xlen_t       result;
    reg_addr_t   out_rd_addr;
    logic        out_wen;
    logic [31:0] rng_state = 32'h0d8e15b7;
    int          timeouts  = 0;
    int          checks;

    exu_top UUT (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // --------------------
    // Random helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic logic ready_draw();
        return (next_rand() % 4) != 0;   // Low about one cycle in four
    endfunction

    function automatic xlen_t pick_operand();
        case (next_rand() % 8)
            0: return '0;
            1: return '1;
            2: return MIN_VALUE;
            default: return {next_rand(), next_rand()};
        endcase
    endfunction

    // Present one operation and hold it until accepted
    task automatic issue(input alu_op_t o, input xlen_t a, input xlen_t b, input logic w);
        int   waited;
        logic fired;
        waited = 0;
        fired  = 1'b0;
        in_valid  <= 1'b1;
        op        <= o;
        src1      <= a;
        src2      <= b;
        word_op   <= w;
        rd_addr   <= reg_addr_t'(next_rand());
        wen       <= 1'(next_rand() % 2);
        out_ready <= ready_draw();
        while (!fired && waited < TIMEOUT) begin
            @(negedge clock);
            fired = in_ready;
            @(posedge clock);
            if (!fired) begin
                out_ready <= ready_draw();
            end
            waited++;
        end
        if (!fired) begin
            timeouts++;
            $display("Timeout at %0t: %s was not accepted within %0d cycles",
                     $time, o.name(), TIMEOUT);
        end
    endtask

    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        op        = OP_ADD;
        src1      = '0;
        src2      = '0;
        word_op   = 1'b0;
        rd_addr   = '0;
        wen       = 1'b0;
        out_ready = 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        repeat (2) @(posedge clock);

        // Every operation in plain and word form
        for (int i = 0; i < 15; i++) begin
            issue(alu_op_t'(i), pick_operand(), pick_operand(), 1'b0);
            issue(alu_op_t'(i), pick_operand(), pick_operand(), 1'b1);
        end

        // Divide corners
        issue(OP_DIV, MIN_VALUE, '1, 1'b0);
        issue(OP_REM, MIN_VALUE, '1, 1'b0);
        issue(OP_DIV, MIN_VALUE, '0, 1'b0);
        issue(OP_DIVU, '1, '0, 1'b0);
        issue(OP_REM, MIN_VALUE + 64'd5, '0, 1'b0);
        issue(OP_REMU, 64'd12345, '0, 1'b0);
        issue(OP_DIV, 64'd7, '1, 1'b1);

        for (int n = 0; n < 300 && timeouts == 0; n++) begin
            if (next_rand() % 4 == 0) begin   // Idle gap
                in_valid  <= 1'b0;
                out_ready <= ready_draw();
                @(posedge clock);
            end
            issue(alu_op_t'(next_rand() % 15), pick_operand(), pick_operand(),
                  1'(next_rand() % 2));
        end

        in_valid  <= 1'b0;
        out_ready <= 1'b1;
        repeat (3) @(posedge clock);

        checks = UUT.u_checker.fail_count;
        $display("Errors: %0d timeout, %0d assertion", timeouts, checks);
        if (timeouts == 0 && checks == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
common/exu_pkg.sv
exu/exu_alu.sv
exu/exu_multiplier.sv
exu/exu_divider.sv
exu/exu_control.sv
design/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - exu/exu_alu.sv
  - exu/exu_multiplier.sv
  - exu/exu_divider.sv
  - exu/exu_control.sv
  - design/exu_top.sv
  - target: test
    files:
      - verif/exu_checker.sv
      - verif/exu_tb.sv
